//--- common/noc_pkg.sv
package noc_pkg;

  // Router geometry
  localparam int NUM_PORTS          = 4;
  localparam int PORT_W             = $clog2(NUM_PORTS);
  localparam int DATA_W             = 32;
  localparam int DEFAULT_FIFO_DEPTH = 4;

  // Names one router port
  typedef logic [PORT_W-1:0] port_id_t;

  // Flit payload
  typedef logic [DATA_W-1:0] data_t;

  // One bit per port, used for request, grant and pop vectors
  typedef logic [NUM_PORTS-1:0] port_vec_t;

  // A single flit on the fabric, 36 bits
  typedef struct packed {
    logic     head;  // First flit of a packet
    logic     tail;  // Last flit, may coincide with head
    port_id_t dest;  // Output port, valid in the head flit only
    data_t    data;
  } noc_flit_t;

  // Output switch lock state
  typedef enum logic {
    IDLE,
    LOCKED
  } sw_state_e;

endpackage

//--- router/input_port.sv
`timescale 1ns/10ps

module input_port #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  noc_pkg::noc_flit_t  flit_i,
  input  logic                valid_i,
  output logic                ready_o,
  output noc_pkg::noc_flit_t  fifo_flit_o,
  output noc_pkg::port_vec_t  req_o,
  input  noc_pkg::port_vec_t  pop_i
);

  import noc_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  noc_flit_t mem [FIFO_DEPTH];  // Flit storage

  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  cnt_t      count_q;
  port_id_t  route_q;           // Route of the packet in progress
  port_id_t  cur_route;
  logic      full;
  logic      empty;
  logic      wr;
  logic      pop;

  assign full  = (count_q == cnt_t'(FIFO_DEPTH));
  assign empty = (count_q == '0);
  assign wr    = valid_i && ready_o;
  assign pop   = |pop_i;

  assign ready_o     = !full;
  assign fifo_flit_o = mem[rd_ptr_q];  // Read is combinational

  // A head at the FIFO output names its route directly
  assign cur_route = fifo_flit_o.head ? fifo_flit_o.dest : route_q;

  always_comb begin
    req_o = '0;
    if (!empty) begin
      req_o[cur_route] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Body flits follow the route of the head that went before
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      route_q <= '0;
    end else if (pop && fifo_flit_o.head) begin
      route_q <= fifo_flit_o.dest;
    end
  end

  // A full FIFO that is not drained keeps its head flit
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    full && !pop |=> $stable(fifo_flit_o)
  );

  // Only one switch may take this port's head flit at a time
  a_pop_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0(pop_i)
  );

endmodule

//--- router/output_switch.sv
`timescale 1ns/10ps

module output_switch (
  input  logic                clk,
  input  logic                rst_n_i,
  input  noc_pkg::port_vec_t  req_i,
  input  noc_pkg::noc_flit_t  flit_i [noc_pkg::NUM_PORTS],
  input  logic                ready_i,
  output noc_pkg::noc_flit_t  flit_o,
  output logic                valid_o,
  output noc_pkg::port_vec_t  pop_o
);

  import noc_pkg::*;

  sw_state_e state_q;
  port_id_t  owner_q;   // Input holding the lock
  port_id_t  last_q;    // Last input served, for round-robin
  port_id_t  pick;
  port_id_t  idx;
  port_id_t  sel;
  port_vec_t gnt;
  logic      active;
  logic      xfer;
  logic      tail_xfer;

  // Search starts one past the last input served
  always_comb begin
    pick = last_q;
    idx  = last_q;
    for (int k = NUM_PORTS; k >= 1; k--) begin
      idx = port_id_t'(int'(last_q) + k);
      if (req_i[idx]) begin
        pick = idx;  // Smallest offset wins
      end
    end
  end

  assign sel    = (state_q == LOCKED) ? owner_q : pick;
  assign active = (state_q == LOCKED) || (|req_i);

  always_comb begin
    gnt = '0;
    if (active) begin
      gnt[sel] = 1'b1;
    end
  end

  assign flit_o    = flit_i[sel];
  assign valid_o   = req_i[sel];
  assign xfer      = valid_o && ready_i;
  assign tail_xfer = xfer && flit_o.tail;
  assign pop_o     = xfer ? gnt : '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      owner_q <= '0;
      last_q  <= port_id_t'(NUM_PORTS - 1);  // Input 0 goes first
    end else begin
      case (state_q)
        IDLE: begin
          if (|req_i) begin
            owner_q <= pick;
            // A single-flit packet leaves at once and anything else holds the grant
            if (tail_xfer) begin
              last_q <= pick;
            end else begin
              state_q <= LOCKED;
            end
          end
        end
        LOCKED: begin
          if (tail_xfer) begin
            state_q <= IDLE;
            last_q  <= owner_q;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // In IDLE the single grant goes to an input that requests
  a_gnt_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0(gnt) && ((state_q == LOCKED) || (req_i == '0) || ((gnt & req_i) != '0))
  );

  // The owner holds the grant until its tail has gone
  a_lock_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (state_q == LOCKED) && !tail_xfer |=> (state_q == LOCKED) && $stable(gnt)
  );

  // Stalled output keeps the same flit, which relies on the input FIFO holding it
  a_stall_stable: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(flit_o)
  );

endmodule

//--- design/noc_router.sv
`timescale 1ns/10ps

module noc_router #(
  parameter int FIFO_DEPTH = noc_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  noc_pkg::noc_flit_t  in_flit_i   [noc_pkg::NUM_PORTS],
  input  noc_pkg::port_vec_t  in_valid_i,
  output noc_pkg::port_vec_t  in_ready_o,
  output noc_pkg::noc_flit_t  out_flit_o  [noc_pkg::NUM_PORTS],
  output noc_pkg::port_vec_t  out_valid_o,
  input  noc_pkg::port_vec_t  out_ready_i
);

  import noc_pkg::*;

  noc_flit_t fifo_flit [NUM_PORTS];  // Head-of-FIFO flit per input
  port_vec_t req       [NUM_PORTS];  // Indexed by input, bit per output
  port_vec_t req_t     [NUM_PORTS];  // Indexed by output, bit per input
  port_vec_t pop       [NUM_PORTS];  // Indexed by output, bit per input
  port_vec_t pop_t     [NUM_PORTS];  // Indexed by input, bit per output

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xpose
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_bit
      assign req_t[o][i] = req[i][o];
      assign pop_t[i][o] = pop[o][i];
    end
  end

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    input_port #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) input_port_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .flit_i      (in_flit_i[i]),
      .valid_i     (in_valid_i[i]),
      .ready_o     (in_ready_o[i]),
      .fifo_flit_o (fifo_flit[i]),
      .req_o       (req[i]),
      .pop_i       (pop_t[i])
    );
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    output_switch output_switch_i (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (req_t[o]),
      .flit_i  (fifo_flit),
      .ready_i (out_ready_i[o]),
      .flit_o  (out_flit_o[o]),
      .valid_o (out_valid_o[o]),
      .pop_o   (pop[o])
    );
  end

endmodule

//--- tests/tb_packet_table.svh
`ifndef TB_PACKET_TABLE_SVH
`define TB_PACKET_TABLE_SVH

  typedef struct packed {
    port_id_t   src;
    port_id_t   dest;
    logic [7:0] len;   // Flits in the packet
    data_t      base;  // Payload of flit k is base + k
  } pkt_row_t;

  localparam int NUM_PKTS = 16;

  // Columns are source, destination, length in flits and data base
  // Top nibble of the data base is the source plus one
  localparam pkt_row_t PKT_TABLE [NUM_PKTS] = '{
    '{2'd0, 2'd0, 8'd1, 32'h1000_0000},  // Single-flit packets, rows 0 to 7
    '{2'd0, 2'd2, 8'd1, 32'h1000_0100},
    '{2'd1, 2'd1, 8'd1, 32'h2000_0000},
    '{2'd1, 2'd3, 8'd1, 32'h2000_0100},
    '{2'd2, 2'd2, 8'd1, 32'h3000_0000},
    '{2'd2, 2'd0, 8'd1, 32'h3000_0100},
    '{2'd3, 2'd3, 8'd1, 32'h4000_0000},
    '{2'd3, 2'd1, 8'd1, 32'h4000_0100},
    '{2'd0, 2'd1, 8'd4, 32'h1000_1000},  // Two sources share output 1, rows 8 to 11
    '{2'd2, 2'd1, 8'd4, 32'h3000_1000},
    '{2'd0, 2'd1, 8'd3, 32'h1000_1100},
    '{2'd2, 2'd1, 8'd5, 32'h3000_1100},
    '{2'd1, 2'd3, 8'd6, 32'h2000_1000},  // Longer than the default FIFO
    '{2'd3, 2'd0, 8'd2, 32'h4000_1000},
    '{2'd3, 2'd1, 8'd3, 32'h4000_1100},
    '{2'd1, 2'd0, 8'd2, 32'h2000_1100}
  };

`endif

//--- tests/tb_noc_router.sv
`timescale 1ns/10ps

module tb_noc_router;

  import noc_pkg::*;

  `include "tb_packet_table.svh"

  localparam int TIMEOUT_CYCLES = 2000;

  logic      clk;
  logic      rst_n_i;
  noc_flit_t in_flit_i  [NUM_PORTS];
  port_vec_t in_valid_i;
  port_vec_t in_ready_o;
  noc_flit_t out_flit_o [NUM_PORTS];
  port_vec_t out_valid_o;
  port_vec_t out_ready_i;

  noc_flit_t exp_q [NUM_PORTS*NUM_PORTS][$];  // Index is source * NUM_PORTS + dest

  logic      stalled   [NUM_PORTS];  // Output held by back-pressure last cycle
  noc_flit_t held_flit [NUM_PORTS];
  logic      in_packet [NUM_PORTS];
  port_id_t  owner_src [NUM_PORTS];

  logic random_ready;
  logic timed_out;
  int   errors;
  int   tests_run;
  int   tests_failed;

  noc_router #(
    .FIFO_DEPTH (DEFAULT_FIFO_DEPTH)
  ) noc_router_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_flit_i   (in_flit_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Output ready is random only while random_ready is set
  initial begin
    void'($urandom(32'h8039_664b));
    out_ready_i = '1;
    forever begin
      @(posedge clk);
      out_ready_i <= random_ready ? port_vec_t'($urandom) : '1;
    end
  end

  function automatic noc_flit_t make_flit(input int r, input int k);
    noc_flit_t f;
    f.head = (k == 0);
    f.tail = (k == int'(PKT_TABLE[r].len) - 1);
    f.dest = PKT_TABLE[r].dest;
    f.data = PKT_TABLE[r].base + data_t'(k);
    return f;
  endfunction

  function automatic logic drained();
    logic done;
    done = 1'b1;
    for (int q = 0; q < NUM_PORTS * NUM_PORTS; q++) begin
      if (exp_q[q].size() != 0) done = 1'b0;
    end
    return done;
  endfunction

  // Sends one source's rows, holding each flit until in_ready_o takes it
  task automatic send_source(input int src, input int first, input int last);
    noc_flit_t f;
    int        wait_cycles;
    for (int r = first; r <= last && !timed_out; r++) begin
      if (int'(PKT_TABLE[r].src) == src) begin
        for (int k = 0; k < int'(PKT_TABLE[r].len); k++) begin
          f = make_flit(r, k);
          @(posedge clk);
          in_flit_i[src]  <= f;
          in_valid_i[src] <= 1'b1;
          wait_cycles = 0;
          do begin
            @(negedge clk);
            wait_cycles++;
          end while (!in_ready_o[src] && wait_cycles < TIMEOUT_CYCLES);
          if (!in_ready_o[src]) begin
            $display("Timeout: input %0d never became ready for flit %h", src, f);
            timed_out = 1'b1;
            break;
          end
        end
      end
    end
    @(posedge clk);  // Last flit transfers here
    in_valid_i[src] <= 1'b0;
  endtask

  task automatic check_output(input int o);
    noc_flit_t got;
    noc_flit_t exp;
    int        src;
    int        key;
    got = out_flit_o[o];
    if (stalled[o] && !out_valid_o[o]) begin
      $display("** Error out_valid_o[%0d]: expected 1, got 0 while stalled", o);
      errors++;
    end
    if (stalled[o] && got !== held_flit[o]) begin
      $display("** Error out_flit_o[%0d]: expected %h, got %h while stalled",
               o, held_flit[o], got);
      errors++;
    end
    stalled[o]   = out_valid_o[o] && !out_ready_i[o];
    held_flit[o] = got;
    if (out_valid_o[o] && out_ready_i[o]) begin
      src = int'(got.data[31:28]) - 1;
      if (src < 0 || src >= NUM_PORTS) begin
        $display("Flit %h at output %0d carries data from no known source", got, o);
        errors++;
      end else begin
        if (in_packet[o] && port_id_t'(src) != owner_src[o]) begin
          $display("** Error out_flit_o[%0d] source: expected %h, got %h",
                   o, owner_src[o], src);
          errors++;
        end
        if (got.head) begin
          in_packet[o] = !got.tail;
          owner_src[o] = port_id_t'(src);
        end else if (got.tail) begin
          in_packet[o] = 1'b0;
        end
        key = src * NUM_PORTS + o;
        if (exp_q[key].size() == 0) begin
          $display("Flit %h from input %0d left output %0d but was not expected", got, src, o);
          errors++;
        end else begin
          exp = exp_q[key].pop_front();
          if (got !== exp) begin
            $display("** Error out_flit_o[%0d]: expected %h, got %h", o, exp, got);
            errors++;
          end
        end
      end
    end
  endtask

  // Outputs are stable by the falling edge and a transfer follows on the next rise
  always @(negedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (!rst_n_i) begin
        stalled[o]   = 1'b0;
        held_flit[o] = '0;
        in_packet[o] = 1'b0;
        owner_src[o] = '0;
      end else begin
        check_output(o);
      end
    end
  end

  task automatic report_test(input int num, input string name, input int err_start);
    tests_run++;
    if (errors == err_start && !timed_out) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed, %0d errors", num, name, errors - err_start);
    end
  endtask

  task automatic run_phase(input int num, input string name, input int first,
                           input int last, input logic rand_rdy);
    int err_start;
    int wait_cycles;
    err_start = errors;
    for (int r = first; r <= last; r++) begin
      for (int k = 0; k < int'(PKT_TABLE[r].len); k++) begin
        exp_q[int'(PKT_TABLE[r].src) * NUM_PORTS + int'(PKT_TABLE[r].dest)]
          .push_back(make_flit(r, k));
      end
    end
    random_ready = rand_rdy;
    fork
      send_source(0, first, last);
      send_source(1, first, last);
      send_source(2, first, last);
      send_source(3, first, last);
    join
    random_ready = 1'b0;
    wait_cycles  = 0;
    while (!timed_out && !drained()) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: flits of test %0d were never delivered", num);
        timed_out = 1'b1;
      end
    end
    report_test(num, name, err_start);
  endtask

  initial begin
    int err_start;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    random_ready = 1'b0;
    rst_n_i      = 1'b0;
    in_valid_i   = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_flit_i[p] = '0;
    end
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;

    err_start = errors;
    @(negedge clk);
    if (out_valid_o !== '0) begin
      $display("** Error out_valid_o: expected %h, got %h", 4'h0, out_valid_o);
      errors++;
    end
    if (in_ready_o !== '1) begin
      $display("** Error in_ready_o: expected %h, got %h", 4'hf, in_ready_o);
      errors++;
    end
    report_test(1, "state after reset", err_start);

    run_phase(2, "single-flit routing", 0, 7, 1'b0);
    if (!timed_out) run_phase(3, "no interleaving at a shared output", 8, 11, 1'b0);
    if (!timed_out) run_phase(4, "per-pair order and single delivery", 0, 15, 1'b0);
    if (!timed_out) run_phase(5, "random output back-pressure", 0, 15, 1'b1);

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+tests
common/noc_pkg.sv
router/input_port.sv
router/output_switch.sv
design/noc_router.sv
tests/tb_noc_router.sv

//--- Makefile
TOP = tb_noc_router

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
